/* source/axi_bridge_pkg.sv */
package axi_bridge_pkg;

    typedef logic [31:0] addr_t;    // Byte address
    typedef logic [31:0] data_t;    // One bus word
    typedef logic [3:0]  strb_t;    // One bit per byte lane
    typedef logic        axi_id_t;

    localparam axi_id_t ID_INST = 1'b0;    // Fetch bridge
    localparam axi_id_t ID_DATA = 1'b1;    // Load/store bridge

    // Fetch bridge, read only
    typedef enum logic [1:0] {
        INST_IDLE,
        INST_RADDR,
        INST_RDATA
    } inst_state_t;

    typedef enum logic [2:0] {
        DATA_IDLE,
        DATA_RADDR,
        DATA_RDATA,
        DATA_WADDR,    // AW and W both in flight
        DATA_WRESP
    } data_state_t;

    typedef enum logic {
        ARB_FREE,
        ARB_BUSY
    } arb_state_t;

endpackage : axi_bridge_pkg

/* source/axi4_if.sv */
`timescale 1ns/1ps

interface axi4_if;

    axi_bridge_pkg::addr_t   araddr;
    axi_bridge_pkg::axi_id_t arid;
    logic                    arvalid;
    logic                    arready;

    axi_bridge_pkg::data_t   rdata;
    axi_bridge_pkg::axi_id_t rid;
    logic                    rlast;
    logic                    rvalid;
    logic                    rready;

    axi_bridge_pkg::addr_t   awaddr;
    axi_bridge_pkg::axi_id_t awid;
    logic                    awvalid;
    logic                    awready;

    axi_bridge_pkg::data_t   wdata;
    axi_bridge_pkg::strb_t   wstrb;
    logic                    wlast;
    logic                    wvalid;
    logic                    wready;

    axi_bridge_pkg::axi_id_t bid;
    logic                    bvalid;
    logic                    bready;

    modport m (
        output araddr, arid, arvalid, rready,
        output awaddr, awid, awvalid,
        output wdata, wstrb, wlast, wvalid, bready,
        input  arready, rdata, rid, rlast, rvalid,
        input  awready, wready, bid, bvalid
    );

    modport s (
        input  araddr, arid, arvalid, rready,
        input  awaddr, awid, awvalid,
        input  wdata, wstrb, wlast, wvalid, bready,
        output arready, rdata, rid, rlast, rvalid,
        output awready, wready, bid, bvalid
    );

endinterface : axi4_if

/* source/sram_if.sv */
`timescale 1ns/1ps

interface sram_if;

    logic                  rd_en;
    logic                  wr_en;    // Never high with rd_en
    axi_bridge_pkg::addr_t addr;
    axi_bridge_pkg::data_t wdata;
    axi_bridge_pkg::strb_t wstrb;

    logic                  rd_valid;    // One-cycle pulse
    axi_bridge_pkg::data_t rd_data;
    logic                  wr_done;     // One-cycle pulse

    // Core side
    modport m (
        output rd_en, wr_en, addr, wdata, wstrb,
        input  rd_valid, rd_data, wr_done
    );

    // Bridge side
    modport s (
        input  rd_en, wr_en, addr, wdata, wstrb,
        output rd_valid, rd_data, wr_done
    );

endinterface : sram_if

/* source/axi4_master_inst.sv */
`timescale 1ns/1ps

module axi4_master_inst (
    input  logic axi4_master,
    input  logic rst,
    axi4_if.m    bus,
    sram_if.s    sram
);

    axi_bridge_pkg::inst_state_t state;

    assign bus.arid = axi_bridge_pkg::ID_INST;

    // Fetch port never writes
    assign bus.awaddr  = '0;
    assign bus.awid    = axi_bridge_pkg::ID_INST;
    assign bus.awvalid = 1'b0;
    assign bus.wdata   = '0;
    assign bus.wstrb   = '0;
    assign bus.wlast   = 1'b0;
    assign bus.wvalid  = 1'b0;
    assign bus.bready  = 1'b0;
    assign sram.wr_done = 1'b0;

    always_ff @(posedge axi4_master) begin
        if (rst) begin
            state        <= axi_bridge_pkg::INST_IDLE;
            bus.arvalid  <= 1'b0;
            bus.rready   <= 1'b0;
            sram.rd_valid <= 1'b0;
        end else begin
            sram.rd_valid <= 1'b0;
            case (state)
                axi_bridge_pkg::INST_IDLE: begin
                    bus.rready <= 1'b0;    // R beat taken this cycle
                    if (sram.rd_en && !sram.rd_valid) begin
                        state <= axi_bridge_pkg::INST_RADDR;
                    end
                end
                axi_bridge_pkg::INST_RADDR: begin
                    if (bus.arvalid && bus.arready) begin
                        bus.arvalid <= 1'b0;
                        state       <= axi_bridge_pkg::INST_RDATA;
                    end else if (!bus.arvalid) begin
                        bus.arvalid <= 1'b1;
                        bus.araddr  <= sram.addr;
                    end
                end
                axi_bridge_pkg::INST_RDATA: begin
                    if (bus.rvalid && bus.rlast) begin
                        bus.rready    <= 1'b1;    // Handshake completes next cycle
                        sram.rd_valid <= 1'b1;
                        sram.rd_data  <= bus.rdata;
                        state         <= axi_bridge_pkg::INST_IDLE;
                    end
                end
                default: state <= axi_bridge_pkg::INST_IDLE;
            endcase
        end
    end

endmodule : axi4_master_inst

/* source/axi4_master_data.sv */
`timescale 1ns/1ps

module axi4_master_data (
    input  logic axi4_master,
    input  logic rst,
    axi4_if.m    bus,
    sram_if.s    sram
);

    axi_bridge_pkg::data_state_t state;

    logic aw_done;    // AW accepted, W may still be pending
    logic w_done;
    logic aw_fin;
    logic w_fin;
    logic pulse_out;

    assign bus.arid  = axi_bridge_pkg::ID_DATA;
    assign bus.awid  = axi_bridge_pkg::ID_DATA;
    assign bus.wlast = 1'b1;    // Single beat

    assign aw_fin    = aw_done || (bus.awvalid && bus.awready);
    assign w_fin     = w_done || (bus.wvalid && bus.wready);
    assign pulse_out = sram.rd_valid || sram.wr_done;

    always_ff @(posedge axi4_master) begin
        if (rst) begin
            state         <= axi_bridge_pkg::DATA_IDLE;
            bus.arvalid   <= 1'b0;
            bus.awvalid   <= 1'b0;
            bus.wvalid    <= 1'b0;
            bus.rready    <= 1'b0;
            bus.bready    <= 1'b0;
            aw_done       <= 1'b0;
            w_done        <= 1'b0;
            sram.rd_valid <= 1'b0;
            sram.wr_done  <= 1'b0;
        end else begin
            sram.rd_valid <= 1'b0;
            sram.wr_done  <= 1'b0;
            case (state)
                axi_bridge_pkg::DATA_IDLE: begin
                    bus.rready <= 1'b0;
                    // Core still holds its enable during the pulse
                    if (!pulse_out && sram.rd_en) begin
                        state <= axi_bridge_pkg::DATA_RADDR;
                    end else if (!pulse_out && sram.wr_en) begin
                        state <= axi_bridge_pkg::DATA_WADDR;
                    end
                end
                axi_bridge_pkg::DATA_RADDR: begin
                    if (bus.arvalid && bus.arready) begin
                        bus.arvalid <= 1'b0;
                        state       <= axi_bridge_pkg::DATA_RDATA;
                    end else if (!bus.arvalid) begin
                        bus.arvalid <= 1'b1;
                        bus.araddr  <= sram.addr;
                    end
                end
                axi_bridge_pkg::DATA_RDATA: begin
                    if (bus.rvalid && bus.rlast) begin
                        bus.rready    <= 1'b1;
                        sram.rd_valid <= 1'b1;
                        sram.rd_data  <= bus.rdata;
                        state         <= axi_bridge_pkg::DATA_IDLE;
                    end
                end
                axi_bridge_pkg::DATA_WADDR: begin
                    if (!aw_done) begin
                        if (bus.awvalid && bus.awready) begin
                            bus.awvalid <= 1'b0;
                            aw_done     <= 1'b1;
                        end else if (!bus.awvalid) begin
                            bus.awvalid <= 1'b1;
                            bus.awaddr  <= sram.addr;
                        end
                    end
                    if (!w_done) begin
                        if (bus.wvalid && bus.wready) begin
                            bus.wvalid <= 1'b0;
                            w_done     <= 1'b1;
                        end else if (!bus.wvalid) begin
                            bus.wvalid <= 1'b1;
                            bus.wdata  <= sram.wdata;
                            bus.wstrb  <= sram.wstrb;
                        end
                    end
                    if (aw_fin && w_fin) begin
                        aw_done    <= 1'b0;
                        w_done     <= 1'b0;
                        bus.bready <= 1'b1;
                        state      <= axi_bridge_pkg::DATA_WRESP;
                    end
                end
                axi_bridge_pkg::DATA_WRESP: begin
                    if (bus.bvalid && bus.bready) begin
                        bus.bready   <= 1'b0;
                        sram.wr_done <= 1'b1;
                        state        <= axi_bridge_pkg::DATA_IDLE;
                    end
                end
                default: state <= axi_bridge_pkg::DATA_IDLE;
            endcase
        end
    end

endmodule : axi4_master_data

/* source/axi4_bus_arbiter.sv */
`timescale 1ns/1ps

module axi4_bus_arbiter (
    input  logic axi4_master,
    input  logic rst,
    axi4_if.s    inst_bus,
    axi4_if.s    data_bus,
    axi4_if.m    mem_bus
);

    axi_bridge_pkg::arb_state_t state;
    axi_bridge_pkg::axi_id_t    grant;
    axi_bridge_pkg::axi_id_t    last_grant;
    axi_bridge_pkg::axi_id_t    pick;

    logic inst_req;
    logic data_req;
    logic busy;
    logic sel_data;
    logic txn_end;

    assign inst_req = inst_bus.arvalid || inst_bus.awvalid;
    assign data_req = data_bus.arvalid || data_bus.awvalid;
    assign busy     = (state == axi_bridge_pkg::ARB_BUSY);
    assign sel_data = (grant == axi_bridge_pkg::ID_DATA);

    // Round robin on a tie
    assign pick = (inst_req && data_req) ? ~last_grant :
                  (data_req ? axi_bridge_pkg::ID_DATA : axi_bridge_pkg::ID_INST);

    assign txn_end = (mem_bus.rvalid && mem_bus.rready && mem_bus.rlast) ||
                     (mem_bus.bvalid && mem_bus.bready);

    always_ff @(posedge axi4_master) begin
        if (rst) begin
            state      <= axi_bridge_pkg::ARB_FREE;
            grant      <= axi_bridge_pkg::ID_INST;
            last_grant <= axi_bridge_pkg::ID_DATA;    // Fetch wins the first tie
        end else begin
            case (state)
                axi_bridge_pkg::ARB_FREE: begin
                    if (inst_req || data_req) begin
                        grant <= pick;
                        state <= axi_bridge_pkg::ARB_BUSY;
                    end
                end
                axi_bridge_pkg::ARB_BUSY: begin
                    if (txn_end) begin
                        last_grant <= grant;
                        state      <= axi_bridge_pkg::ARB_FREE;
                    end
                end
                default: state <= axi_bridge_pkg::ARB_FREE;
            endcase
        end
    end

    // Request side mux
    assign mem_bus.araddr  = sel_data ? data_bus.araddr : inst_bus.araddr;
    assign mem_bus.arid    = sel_data ? data_bus.arid : inst_bus.arid;
    assign mem_bus.arvalid = busy && (sel_data ? data_bus.arvalid : inst_bus.arvalid);
    assign mem_bus.awaddr  = sel_data ? data_bus.awaddr : inst_bus.awaddr;
    assign mem_bus.awid    = sel_data ? data_bus.awid : inst_bus.awid;
    assign mem_bus.awvalid = busy && (sel_data ? data_bus.awvalid : inst_bus.awvalid);
    assign mem_bus.wdata   = sel_data ? data_bus.wdata : inst_bus.wdata;
    assign mem_bus.wstrb   = sel_data ? data_bus.wstrb : inst_bus.wstrb;
    assign mem_bus.wlast   = sel_data ? data_bus.wlast : inst_bus.wlast;
    assign mem_bus.wvalid  = busy && (sel_data ? data_bus.wvalid : inst_bus.wvalid);
    assign mem_bus.rready  = busy && (sel_data ? data_bus.rready : inst_bus.rready);
    assign mem_bus.bready  = busy && (sel_data ? data_bus.bready : inst_bus.bready);

    // Loser sees ready low
    assign inst_bus.arready = busy && !sel_data && mem_bus.arready;
    assign inst_bus.awready = busy && !sel_data && mem_bus.awready;
    assign inst_bus.wready  = busy && !sel_data && mem_bus.wready;
    assign data_bus.arready = busy && sel_data && mem_bus.arready;
    assign data_bus.awready = busy && sel_data && mem_bus.awready;
    assign data_bus.wready  = busy && sel_data && mem_bus.wready;

    // Responses steered by ID
    assign inst_bus.rdata  = mem_bus.rdata;
    assign inst_bus.rid    = mem_bus.rid;
    assign inst_bus.rlast  = mem_bus.rlast;
    assign inst_bus.rvalid = mem_bus.rvalid && (mem_bus.rid == axi_bridge_pkg::ID_INST);
    assign inst_bus.bid    = mem_bus.bid;
    assign inst_bus.bvalid = mem_bus.bvalid && (mem_bus.bid == axi_bridge_pkg::ID_INST);
    assign data_bus.rdata  = mem_bus.rdata;
    assign data_bus.rid    = mem_bus.rid;
    assign data_bus.rlast  = mem_bus.rlast;
    assign data_bus.rvalid = mem_bus.rvalid && (mem_bus.rid == axi_bridge_pkg::ID_DATA);
    assign data_bus.bid    = mem_bus.bid;
    assign data_bus.bvalid = mem_bus.bvalid && (mem_bus.bid == axi_bridge_pkg::ID_DATA);

endmodule : axi4_bus_arbiter

/* source/fetch_bus_top.sv */
`timescale 1ns/1ps

module fetch_bus_top (
    input  logic                    axi4_master,
    input  logic                    rst,

    input  logic                    inst_rd_en,
    input  axi_bridge_pkg::addr_t   inst_addr,
    output logic                    inst_rd_valid,
    output axi_bridge_pkg::data_t   inst_rd_data,

    input  logic                    data_rd_en,
    input  logic                    data_wr_en,
    input  axi_bridge_pkg::addr_t   data_addr,
    input  axi_bridge_pkg::data_t   data_wdata,
    input  axi_bridge_pkg::strb_t   data_wstrb,
    output logic                    data_rd_valid,
    output axi_bridge_pkg::data_t   data_rd_data,
    output logic                    data_wr_done,

    output axi_bridge_pkg::addr_t   m_araddr,
    output axi_bridge_pkg::axi_id_t m_arid,
    output logic                    m_arvalid,
    input  logic                    m_arready,
    input  axi_bridge_pkg::data_t   m_rdata,
    input  axi_bridge_pkg::axi_id_t m_rid,
    input  logic                    m_rlast,
    input  logic                    m_rvalid,
    output logic                    m_rready,
    output axi_bridge_pkg::addr_t   m_awaddr,
    output axi_bridge_pkg::axi_id_t m_awid,
    output logic                    m_awvalid,
    input  logic                    m_awready,
    output axi_bridge_pkg::data_t   m_wdata,
    output axi_bridge_pkg::strb_t   m_wstrb,
    output logic                    m_wlast,
    output logic                    m_wvalid,
    input  logic                    m_wready,
    input  axi_bridge_pkg::axi_id_t m_bid,
    input  logic                    m_bvalid,
    output logic                    m_bready
);

    axi4_if inst_bus ();
    axi4_if data_bus ();
    axi4_if mem_bus ();
    sram_if inst_sram ();
    sram_if data_sram ();

    assign inst_sram.rd_en = inst_rd_en;
    assign inst_sram.wr_en = 1'b0;    // Fetch side is read only
    assign inst_sram.addr  = inst_addr;
    assign inst_sram.wdata = '0;
    assign inst_sram.wstrb = '0;
    assign inst_rd_valid   = inst_sram.rd_valid;
    assign inst_rd_data    = inst_sram.rd_data;

    assign data_sram.rd_en = data_rd_en;
    assign data_sram.wr_en = data_wr_en;
    assign data_sram.addr  = data_addr;
    assign data_sram.wdata = data_wdata;
    assign data_sram.wstrb = data_wstrb;
    assign data_rd_valid   = data_sram.rd_valid;
    assign data_rd_data    = data_sram.rd_data;
    assign data_wr_done    = data_sram.wr_done;

    assign m_araddr          = mem_bus.araddr;
    assign m_arid            = mem_bus.arid;
    assign m_arvalid         = mem_bus.arvalid;
    assign mem_bus.arready   = m_arready;
    assign mem_bus.rdata     = m_rdata;
    assign mem_bus.rid       = m_rid;
    assign mem_bus.rlast     = m_rlast;
    assign mem_bus.rvalid    = m_rvalid;
    assign m_rready          = mem_bus.rready;
    assign m_awaddr          = mem_bus.awaddr;
    assign m_awid            = mem_bus.awid;
    assign m_awvalid         = mem_bus.awvalid;
    assign mem_bus.awready   = m_awready;
    assign m_wdata           = mem_bus.wdata;
    assign m_wstrb           = mem_bus.wstrb;
    assign m_wlast           = mem_bus.wlast;
    assign m_wvalid          = mem_bus.wvalid;
    assign mem_bus.wready    = m_wready;
    assign mem_bus.bid       = m_bid;
    assign mem_bus.bvalid    = m_bvalid;
    assign m_bready          = mem_bus.bready;

    axi4_master_inst i_inst_bridge (
        .axi4_master (axi4_master),
        .rst         (rst),
        .bus         (inst_bus.m),
        .sram        (inst_sram.s)
    );

    axi4_master_data i_data_bridge (
        .axi4_master (axi4_master),
        .rst         (rst),
        .bus         (data_bus.m),
        .sram        (data_sram.s)
    );

    axi4_bus_arbiter i_arbiter (
        .axi4_master (axi4_master),
        .rst         (rst),
        .inst_bus    (inst_bus.s),
        .data_bus    (data_bus.s),
        .mem_bus     (mem_bus.m)
    );

endmodule : fetch_bus_top

/* verif/fetch_bus_assertions.sv */
`timescale 1ns/1ps

module fetch_bus_assertions (
    input logic                    axi4_master,
    input logic                    rst,
    input axi_bridge_pkg::addr_t   m_araddr,
    input axi_bridge_pkg::axi_id_t m_arid,
    input logic                    m_arvalid,
    input logic                    m_arready,
    input logic                    m_rvalid,
    input logic                    m_rready,
    input logic                    m_rlast,
    input axi_bridge_pkg::addr_t   m_awaddr,
    input axi_bridge_pkg::axi_id_t m_awid,
    input logic                    m_awvalid,
    input logic                    m_awready,
    input logic                    m_wvalid,
    input logic                    m_bvalid,
    input logic                    m_bready,
    input logic                    inst_rd_valid,
    input logic                    data_rd_valid,
    input logic                    data_wr_done
);

    int   fail_count = 0;
    logic in_flight;    // Address accepted, response not yet taken

    always_ff @(posedge axi4_master) begin
        if (rst) begin
            in_flight <= 1'b0;
        end else if ((m_rvalid && m_rready && m_rlast) || (m_bvalid && m_bready)) begin
            in_flight <= 1'b0;
        end else if ((m_arvalid && m_arready) || (m_awvalid && m_awready)) begin
            in_flight <= 1'b1;
        end
    end

    task automatic note_failure(input string what);
        fail_count++;
        $error("%s", what);
    endtask

    ar_hold: assert property (@(posedge axi4_master) disable iff (rst)
        m_arvalid && !m_arready |=> m_arvalid && $stable(m_araddr) && $stable(m_arid))
        else note_failure("m_arvalid or its payload changed before m_arready");

    aw_hold: assert property (@(posedge axi4_master) disable iff (rst)
        m_awvalid && !m_awready |=> m_awvalid && $stable(m_awaddr) && $stable(m_awid))
        else note_failure("m_awvalid or its payload changed before m_awready");

    // Core-side pulses are single cycle
    inst_pulse: assert property (@(posedge axi4_master) disable iff (rst)
        inst_rd_valid |=> !inst_rd_valid)
        else note_failure("inst_rd_valid stayed high for more than one cycle");

    data_pulse: assert property (@(posedge axi4_master) disable iff (rst)
        data_rd_valid |=> !data_rd_valid)
        else note_failure("data_rd_valid stayed high for more than one cycle");

    done_pulse: assert property (@(posedge axi4_master) disable iff (rst)
        data_wr_done |=> !data_wr_done)
        else note_failure("data_wr_done stayed high for more than one cycle");

    reset_low: assert property (@(posedge axi4_master)
        rst |=> !(m_arvalid || m_awvalid || m_wvalid || m_rready || m_bready ||
                  inst_rd_valid || data_rd_valid || data_wr_done))
        else note_failure("A control output was high right after reset");

    one_at_a_time: assert property (@(posedge axi4_master) disable iff (rst)
        in_flight |-> !($rose(m_arvalid) || $rose(m_awvalid) || $rose(m_wvalid)))
        else note_failure("A new bus request started before the previous one finished");

endmodule : fetch_bus_assertions

bind fetch_bus_top fetch_bus_assertions i_assertions (.*);

/* verif/tb_fetch_bus.sv */
`timescale 1ns/1ps

module tb_fetch_bus;

    localparam int NUM_REQ   = 50;
    localparam int MAX_CYCLE = 40 * NUM_REQ;

    logic        axi4_master;
    logic        rst;
    logic        inst_rd_en, inst_rd_valid;
    logic [31:0] inst_addr, inst_rd_data;
    logic        data_rd_en, data_wr_en, data_rd_valid, data_wr_done;
    logic [31:0] data_addr, data_wdata, data_rd_data;
    logic [3:0]  data_wstrb;
    logic [31:0] m_araddr, m_rdata, m_awaddr, m_wdata;
    logic        m_arid, m_arvalid, m_arready;
    logic        m_rid, m_rlast, m_rvalid, m_rready;
    logic        m_awid, m_awvalid, m_awready;
    logic [3:0]  m_wstrb;
    logic        m_wlast, m_wvalid, m_wready;
    logic        m_bid, m_bvalid, m_bready;

    integer      seed = 32'h4dfe5532;
    int          err_count = 0;
    int          check_count = 0;
    int          fail_tests = 0;
    int          cycles = 0;
    logic [31:0] mem [logic [31:0]];        // Bus side memory
    logic [31:0] ref_mem [logic [31:0]];    // Expected contents
    logic        bus_ids [$];               // ID of each bus transaction

    fetch_bus_top i_dut (.*);

    initial begin
        axi4_master = 1'b0;
        forever #5 axi4_master = ~axi4_master;
    end

    initial begin
        while (cycles < MAX_CYCLE) begin
            @(posedge axi4_master);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLE);
        $display("TESTBENCH FAILED");
        $finish;
    end

    function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] d,
                                                input logic [3:0] strb);
        logic [31:0] res;
        res = old;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                res[8*i +: 8] = d[8*i +: 8];
            end
        end
        return res;
    endfunction

    function automatic logic [31:0] model_word(input logic [31:0] addr);
        if (mem.exists(addr)) begin
            return mem[addr];
        end
        return addr ^ 32'hA5A5_0000;    // Unwritten word
    endfunction

    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        if (ref_mem.exists(addr)) begin
            return ref_mem[addr];
        end
        return addr ^ 32'hA5A5_0000;
    endfunction

    function automatic int total_errors();
        return err_count + i_dut.i_assertions.fail_count;
    endfunction

    task automatic random_delay;
        int n;
        n = $unsigned($random(seed)) % 4;
        repeat (n + 1) @(posedge axi4_master);
        #1;
    endtask

    // Waits for the master's ready on R or B
    task automatic wait_ready(input logic b_chan);
        logic hs;
        hs = 1'b0;
        while (!hs) begin
            @(negedge axi4_master);
            hs = b_chan ? m_bready : m_rready;
            @(posedge axi4_master);
            #1;
        end
    endtask

    task automatic serve_read;
        logic [31:0] a;
        logic        id;
        a = m_araddr;
        id = m_arid;
        bus_ids.push_back(id);
        random_delay();
        m_arready = 1'b1;
        @(posedge axi4_master);
        #1;
        m_arready = 1'b0;
        random_delay();
        m_rdata  = model_word(a);
        m_rid    = id;
        m_rvalid = 1'b1;
        wait_ready(1'b0);
        m_rvalid = 1'b0;
    endtask

    task automatic serve_write;
        logic [31:0] a;
        logic        id;
        logic        w_seen;
        a = m_awaddr;
        id = m_awid;
        bus_ids.push_back(id);
        random_delay();
        m_awready = 1'b1;
        @(posedge axi4_master);
        #1;
        m_awready = 1'b0;
        random_delay();
        m_wready = 1'b1;
        w_seen   = 1'b0;
        while (!w_seen) begin
            @(negedge axi4_master);
            w_seen = m_wvalid;
            if (w_seen) begin
                mem[a] = merge_bytes(model_word(a), m_wdata, m_wstrb);
                compare_word("m_wlast", 32'h1, {31'h0, m_wlast});
            end
            @(posedge axi4_master);
            #1;
        end
        m_wready = 1'b0;
        random_delay();
        m_bid    = id;
        m_bvalid = 1'b1;
        wait_ready(1'b1);
        m_bvalid = 1'b0;
    endtask

    // AXI slave memory, one transaction at a time
    initial begin
        m_arready = 1'b0;
        m_awready = 1'b0;
        m_wready  = 1'b0;
        m_rvalid  = 1'b0;
        m_bvalid  = 1'b0;
        m_rdata   = '0;
        m_rid     = 1'b0;
        m_rlast   = 1'b1;
        m_bid     = 1'b0;
        forever begin
            @(negedge axi4_master);
            if (m_arvalid) begin
                serve_read();
            end else if (m_awvalid) begin
                serve_write();
            end
        end
    end

    task automatic compare_word(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        check_count++;
        if (act !== exp) begin
            err_count++;
            $display("ERR %0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic fetch(input logic [31:0] addr);
        inst_rd_en = 1'b1;
        inst_addr  = addr;
        do begin
            @(posedge axi4_master);
            #1;
        end while (!inst_rd_valid);
        compare_word("inst_rd_data", expected_word(addr), inst_rd_data);
        inst_rd_en = 1'b0;
    endtask

    task automatic data_access(input logic wr, input logic [31:0] addr,
                               input logic [31:0] d, input logic [3:0] strb);
        data_rd_en = !wr;
        data_wr_en = wr;
        data_addr  = addr;
        data_wdata = d;
        data_wstrb = strb;
        do begin
            @(posedge axi4_master);
            #1;
        end while (!(wr ? data_wr_done : data_rd_valid));
        if (wr) begin
            ref_mem[addr] = merge_bytes(expected_word(addr), d, strb);
        end else begin
            compare_word("data_rd_data", expected_word(addr), data_rd_data);
        end
        data_rd_en = 1'b0;
        data_wr_en = 1'b0;
    endtask

    task automatic verify_ids(input string name, input logic want);
        foreach (bus_ids[i]) begin
            compare_word(name, {31'h0, want}, {31'h0, bus_ids[i]});
        end
    endtask

    task automatic alternation;
        for (int i = 1; i < bus_ids.size(); i++) begin
            check_count++;
            if (bus_ids[i] === bus_ids[i - 1]) begin
                err_count++;
                $display("Bus grant did not alternate at transaction %0d", i);
            end
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        if (total_errors() == errs_before) begin
            $display("%s: ok", name);
        end else begin
            fail_tests++;
            $display("%s: %0d errors", name, total_errors() - errs_before);
        end
    endtask

    initial begin
        int errs;
        rst        = 1'b1;
        inst_rd_en = 1'b0;
        inst_addr  = '0;
        data_rd_en = 1'b0;
        data_wr_en = 1'b0;
        data_addr  = '0;
        data_wdata = '0;
        data_wstrb = '0;
        repeat (3) @(posedge axi4_master);
        #1;
        rst = 1'b0;

        errs = total_errors();
        repeat (8) begin
            @(posedge axi4_master);
            #1;
            compare_word("idle control outputs", 32'h0,
                         {24'h0, m_arvalid, m_awvalid, m_wvalid, m_rready, m_bready,
                          inst_rd_valid, data_rd_valid, data_wr_done});
        end
        end_test("reset state", errs);

        errs = total_errors();
        bus_ids.delete();
        repeat (10) fetch($random(seed) & 32'hFFFF_FFFC);
        verify_ids("m_arid", 1'b0);
        end_test("instruction fetch", errs);

        errs = total_errors();
        bus_ids.delete();
        data_access(1'b1, 32'h0000_1000, 32'h1122_3344, 4'hF);
        data_access(1'b1, 32'h0000_1004, 32'h5566_7788, 4'h5);    // Onto an unwritten word
        data_access(1'b1, 32'h0000_1008, 32'h99AA_BBCC, 4'hF);
        data_access(1'b1, 32'h0000_1008, 32'hDDEE_FF00, 4'hA);
        data_access(1'b0, 32'h0000_1000, '0, '0);
        data_access(1'b0, 32'h0000_1004, '0, '0);
        data_access(1'b0, 32'h0000_1008, '0, '0);
        verify_ids("m_awid/m_arid", 1'b1);
        end_test("data write and read-back", errs);

        errs = total_errors();
        fetch(32'h0000_3FFC);    // Fetch now holds the last grant
        repeat (3) @(posedge axi4_master);
        #1;
        bus_ids.delete();
        fork
            for (int i = 0; i < 6; i++) fetch(32'h0000_3000 + 4 * i);
            for (int i = 0; i < 6; i++) data_access(1'b0, 32'h0000_5000 + 4 * i, '0, '0);
        join
        compare_word("m_arid", 32'h1, {31'h0, bus_ids[0]});    // Data wins the tie
        alternation();
        end_test("contention", errs);

        // Separate regions keep fetch expectations free of data writes
        errs = total_errors();
        fork
            repeat (10) fetch(32'h0000_2000 | ($random(seed) & 32'hFC));
            repeat (10) data_access($random(seed) & 1, 32'h0000_4000 | ($random(seed) & 32'h1C),
                                    $random(seed), $random(seed) & 4'hF);
        join
        end_test("back-pressure", errs);

        $display("Summary: 5 tests, %0d failed, %0d checks, %0d errors",
                 fail_tests, check_count, total_errors());
        if (total_errors() == 0 && fail_tests == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule : tb_fetch_bus

/* sim.f */
source/axi_bridge_pkg.sv
source/axi4_if.sv
source/sram_if.sv
source/axi4_master_inst.sv
source/axi4_master_data.sv
source/axi4_bus_arbiter.sv
source/fetch_bus_top.sv
verif/fetch_bus_assertions.sv
verif/tb_fetch_bus.sv
